// File: compile.f
common/l15_bridge_pkg.sv
common/avl_cmd_if.sv
common/l15_req_if.sv
rtl/avl_req_capture.sv
rtl/l15_req_encoder.sv
rtl/l15_req_issue.sv
rtl/l15_resp_decoder.sv
rtl/ao486_l15_bridge.sv
dv/bridge_asserts.sv
dv/tb_ao486_l15_bridge.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_ao486_l15_bridge
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_ao486_l15_bridge.sv
/*
  Directed testbench for the ao486 to L1.5 bridge.
  The L1.5 side is played by tasks, one request in flight at a time.
  Write byte enables outside the supported set are expected as full-word stores.
*/
`default_nettype none

module tb_ao486_l15_bridge import l15_bridge_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int phy_addr_width = 40;
    localparam int clk_period     = 20;
    localparam int num_tests      = 6;
    localparam int test_cycles    = 64;

    logic                      clk;
    logic                      rst_n;
    logic [avl_addr_width-1:0] mem_address;
    logic [data_width-1:0]     mem_writedata;
    logic [3:0]                mem_byteenable;
    logic                      mem_write;
    logic                      mem_read;
    logic                      waitrequest;
    logic                      readdatavalid;
    logic [data_width-1:0]     readdata;
    logic                      l15_val;
    l15_rqtype_e               l15_rqtype;
    l15_size_e                 l15_size;
    logic [phy_addr_width-1:0] l15_address;
    logic [l15_data_width-1:0] l15_data;
    logic                      l15_nc;
    logic                      header_ack;
    logic                      ret_val;
    l15_rettype_e              ret_type;
    logic [l15_data_width-1:0] ret_data_0;
    logic [l15_data_width-1:0] ret_data_1;
    logic                      req_ack;
    logic                      ao486_int;

    int          errors;
    int          checks;
    string       test_name;
    logic [31:0] rnd_state;

    ao486_l15_bridge #(.phy_addr_width(phy_addr_width)) uut (
        .clk                                (clk),
        .rst_n                              (rst_n),
        .ao486_transducer_mem_address       (mem_address),
        .ao486_transducer_mem_writedata     (mem_writedata),
        .ao486_transducer_mem_byteenable    (mem_byteenable),
        .ao486_transducer_mem_write         (mem_write),
        .ao486_transducer_mem_read          (mem_read),
        .transducer_ao486_mem_waitrequest   (waitrequest),
        .transducer_ao486_mem_readdatavalid (readdatavalid),
        .transducer_ao486_mem_readdata      (readdata),
        .transducer_l15_val                 (l15_val),
        .transducer_l15_rqtype              (l15_rqtype),
        .transducer_l15_size                (l15_size),
        .transducer_l15_address             (l15_address),
        .transducer_l15_data                (l15_data),
        .transducer_l15_nc                  (l15_nc),
        .l15_transducer_header_ack          (header_ack),
        .l15_transducer_val                 (ret_val),
        .l15_transducer_returntype          (ret_type),
        .l15_transducer_data_0              (ret_data_0),
        .l15_transducer_data_1              (ret_data_1),
        .transducer_l15_req_ack             (req_ack),
        .ao486_int                          (ao486_int)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [63:0] v);
        rnd_state = xorshift32(rnd_state);
        v[63:32]  = rnd_state;
        rnd_state = xorshift32(rnd_state);
        v[31:0]   = rnd_state;
    endtask

    function automatic logic [phy_addr_width-1:0] byte_addr(input logic [29:0] addr,
                                                            input int off);
        return (phy_addr_width'(addr) << 2) + phy_addr_width'(off);
    endfunction

    task automatic fail_value(input string what, input string exp, input string act);
        errors++;
        $display("CHECK FAILED %s %s: expected %s, actual %s", test_name, what, exp, act);
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) fail_value(what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, act);
        checks++;
        if (act !== exp) fail_value(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_dword(input string what, input logic [63:0] exp, act);
        checks++;
        if (act !== exp) fail_value(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_addr(input string what, input logic [phy_addr_width-1:0] exp, act);
        checks++;
        if (act !== exp) fail_value(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_size(input string what, input l15_size_e exp, act);
        checks++;
        if (act !== exp) fail_value(what, exp.name(), act.name());
    endtask

    task automatic check_rqtype(input string what, input l15_rqtype_e exp, act);
        checks++;
        if (act !== exp) fail_value(what, exp.name(), act.name());
    endtask

    // inputs change 2 ns after the edge, outputs are read there too
    task automatic step(input int n = 1);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic present_cmd(input logic is_write, input logic [avl_addr_width-1:0] addr,
                               input logic [3:0] be, input logic [31:0] wd);
        logic busy;
        int   n;
        mem_read       = ~is_write;
        mem_write      = is_write;
        mem_address    = addr;
        mem_byteenable = be;
        mem_writedata  = wd;
        n = 0;
        do begin
            busy = waitrequest;
            step();
            n++;
        end while (busy && n < test_cycles);
        if (busy) begin
            errors++;
            $display("ERROR %s: command never accepted, waitrequest stayed high", test_name);
        end
        mem_read  = 1'b0;
        mem_write = 1'b0;
        check_bit("waitrequest after accept", 1'b1, waitrequest);
    endtask

    task automatic wait_req();
        int n;
        n = 0;
        while (!l15_val && n < test_cycles) begin
            step();
            n++;
        end
        if (!l15_val) begin
            errors++;
            $display("ERROR %s: transducer_l15_val never rose", test_name);
        end
    endtask

    // size, offset and replicated big-endian data of a store
    task automatic expect_store(input logic [3:0] be, input logic [31:0] wd,
                                output l15_size_e size, output int off,
                                output logic [63:0] data);
        logic [3:0]  lanes;
        logic [31:0] bytes;
        int          n;
        lanes = (be inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100}) ?
                be : 4'b1111;
        bytes = '0;
        n     = 0;
        off   = -1;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                bytes = {bytes[23:0], wd[8*i +: 8]};
                n++;
                if (off < 0) off = i;
            end
        end
        size = (n == 1) ? sz_1b : (n == 2) ? sz_2b : sz_4b;
        data = '0;
        for (int j = 0; j < 8 / n; j++) begin
            data = (data << (8 * n)) | 64'(bytes);
        end
    endtask

    task automatic check_read_req(input logic [avl_addr_width-1:0] addr);
        wait_req();
        check_rqtype("rqtype", load_rq, l15_rqtype);
        check_size("size", sz_4b, l15_size);
        check_addr("address", byte_addr(addr, 0), l15_address);
        check_bit("nc", addr[avl_addr_width-1], l15_nc);
    endtask

    task automatic check_write_req(input logic [avl_addr_width-1:0] addr,
                                   input logic [3:0] be, input logic [31:0] wd);
        l15_size_e   size;
        int          off;
        logic [63:0] data;
        expect_store(be, wd, size, off, data);
        wait_req();
        check_rqtype("rqtype", store_rq, l15_rqtype);
        check_size("size", size, l15_size);
        check_addr("address", byte_addr(addr, off), l15_address);
        check_bit("nc", addr[avl_addr_width-1], l15_nc);
        check_dword("store data", data, l15_data);
    endtask

    task automatic ack_header(input int delay);
        l15_rqtype_e               rq;
        l15_size_e                 sz;
        logic [phy_addr_width-1:0] addr;
        logic [63:0]               data;
        rq   = l15_rqtype;
        sz   = l15_size;
        addr = l15_address;
        data = l15_data;
        repeat (delay) begin
            step();
            check_bit("val held", 1'b1, l15_val);
            check_rqtype("rqtype held", rq, l15_rqtype);
            check_size("size held", sz, l15_size);
            check_addr("address held", addr, l15_address);
            check_dword("data held", data, l15_data);
        end
        header_ack = 1'b1;
        step();
        header_ack = 1'b0;
        check_bit("val after header_ack", 1'b0, l15_val);
    endtask

    task automatic hold_busy(input int n);
        repeat (n) begin
            check_bit("val idle", 1'b0, l15_val);
            check_bit("waitrequest busy", 1'b1, waitrequest);
            check_bit("req_ack idle", 1'b0, req_ack);
            step();
        end
    endtask

    task automatic send_return(input l15_rettype_e rt, input logic [63:0] d0, d1);
        ret_val    = 1'b1;
        ret_type   = rt;
        ret_data_0 = d0;
        ret_data_1 = d1;
        #1;
        check_bit("req_ack", 1'b1, req_ack);
        check_bit("waitrequest at return", 1'b1, waitrequest);
        step();
        ret_val = 1'b0;
    endtask

    task automatic finish_read(input logic [avl_addr_width-1:0] addr);
        logic [63:0]  d0;
        logic [63:0]  d1;
        logic [127:0] line;
        logic [31:0]  word;
        next_rand(d0);
        next_rand(d1);
        // word 0 is the top of the line
        line = {d0, d1};
        word = line[127 - 32 * int'(addr[1:0]) -: 32];
        send_return(load_ret, d0, d1);
        check_bit("readdatavalid", 1'b1, readdatavalid);
        check_word("readdata", {<<8{word}}, readdata);
        check_bit("waitrequest after load_ret", 1'b0, waitrequest);
        step();
        check_bit("readdatavalid pulse", 1'b0, readdatavalid);
    endtask

    task automatic finish_write();
        send_return(st_ack, 64'h0, 64'h0);
        check_bit("waitrequest after st_ack", 1'b0, waitrequest);
        check_bit("readdatavalid on store", 1'b0, readdatavalid);
    endtask

    task automatic test_reset();
        test_name = "reset";
        check_bit("waitrequest", 1'b0, waitrequest);
        check_bit("val", 1'b0, l15_val);
        check_bit("readdatavalid", 1'b0, readdatavalid);
        check_bit("ao486_int", 1'b0, ao486_int);
    endtask

    task automatic test_reads();
        logic [63:0]               r;
        logic [avl_addr_width-1:0] addr;
        test_name = "read_offsets";
        for (int i = 0; i < 4; i++) begin
            next_rand(r);
            addr                   = r[29:0];
            addr[1:0]              = 2'(i);
            addr[avl_addr_width-1] = i[0];
            present_cmd(1'b0, addr, 4'hf, '0);
            check_read_req(addr);
            ack_header(i);
            hold_busy(i + 1);
            finish_read(addr);
        end
    endtask

    task automatic test_writes();
        logic [3:0]  pats [8];
        logic [63:0] r;
        test_name = "write_byteenables";
        // last pattern is a split one, sent as a full word
        pats = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111, 4'b0110};
        for (int i = 0; i < 8; i++) begin
            next_rand(r);
            present_cmd(1'b1, r[29:0], pats[i], r[63:32]);
            check_write_req(r[29:0], pats[i], r[63:32]);
            ack_header(1);
            hold_busy(2);
            finish_write();
        end
    endtask

    task automatic test_ack_stall();
        logic [63:0] r;
        test_name = "header_ack_stall";
        next_rand(r);
        present_cmd(1'b0, r[29:0], 4'hf, '0);
        check_read_req(r[29:0]);
        ack_header(5);
        hold_busy(1);
        finish_read(r[29:0]);
    endtask

    task automatic test_busy_read();
        logic [63:0]               r;
        logic [avl_addr_width-1:0] second;
        test_name = "read_while_busy";
        next_rand(r);
        second = r[61:32];
        present_cmd(1'b0, r[29:0], 4'hf, '0);
        check_read_req(r[29:0]);
        mem_read    = 1'b1;
        mem_address = second;
        ack_header(2);
        hold_busy(3);
        // accepted on the edge after the first completes
        finish_read(r[29:0]);
        mem_read = 1'b0;
        check_bit("second read accepted", 1'b1, waitrequest);
        check_read_req(second);
        ack_header(1);
        hold_busy(1);
        finish_read(second);
    endtask

    task automatic test_interrupt();
        logic [63:0] r;
        logic [63:0] d0;
        test_name = "interrupt";
        next_rand(r);
        present_cmd(1'b0, r[29:0], 4'hf, '0);
        check_read_req(r[29:0]);
        ack_header(1);
        next_rand(d0);
        d0[17:16] = 2'b01;
        send_return(int_ret, d0, 64'h0);
        check_bit("ao486_int on wakeup", 1'b1, ao486_int);
        check_bit("waitrequest after int", 1'b1, waitrequest);
        check_bit("readdatavalid after int", 1'b0, readdatavalid);
        step();
        check_bit("ao486_int pulse", 1'b0, ao486_int);
        d0[17:16] = 2'b10;
        send_return(int_ret, d0, 64'h0);
        check_bit("ao486_int other code", 1'b0, ao486_int);
        finish_read(r[29:0]);
    endtask

    initial begin
        #(num_tests * test_cycles * clk_period);
        $display("ERROR: watchdog expired in test %s", test_name);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        mem_address    = '0;
        mem_writedata  = '0;
        mem_byteenable = '0;
        mem_write      = 1'b0;
        mem_read       = 1'b0;
        header_ack     = 1'b0;
        ret_val        = 1'b0;
        ret_type       = load_ret;
        ret_data_0     = '0;
        ret_data_1     = '0;
        errors         = 0;
        checks         = 0;
        rnd_state      = 32'd83766;
        test_name      = "reset";
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_reads();
        test_writes();
        test_ack_stall();
        test_busy_read();
        test_interrupt();
        step(2);
        errors += uut.u_asserts.failures;
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/bridge_asserts.sv
/*
  Protocol assertions, bound to the bridge top level.
  All checks except the reset one are disabled while rst_n is low.
*/
`default_nettype none

module bridge_asserts import l15_bridge_pkg::*; #(
    parameter int phy_addr_width = phy_addr_default
) (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      l15_val,
    input logic                      header_ack,
    input l15_rqtype_e               l15_rqtype,
    input l15_size_e                 l15_size,
    input logic [phy_addr_width-1:0] l15_address,
    input logic [l15_data_width-1:0] l15_data,
    input logic                      l15_nc,
    input logic                      readdatavalid,
    input logic                      ao486_int
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // request waits for the header ack
    val_held: assert property (@(posedge clk) disable iff (!rst_n)
        l15_val && !header_ack |=> l15_val)
        else begin
            failures++;
            $error("transducer_l15_val dropped before header_ack");
        end

    fields_held: assert property (@(posedge clk) disable iff (!rst_n)
        l15_val && !header_ack |=> $stable(l15_rqtype) && $stable(l15_size) &&
            $stable(l15_address) && $stable(l15_data) && $stable(l15_nc))
        else begin
            failures++;
            $error("L1.5 request fields changed before header_ack");
        end

    rdv_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        readdatavalid |=> !readdatavalid)
        else begin
            failures++;
            $error("readdatavalid longer than one cycle");
        end

    int_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ao486_int |=> !ao486_int)
        else begin
            failures++;
            $error("ao486_int longer than one cycle");
        end

    val_in_reset: assert property (@(posedge clk) !rst_n |=> !l15_val)
        else begin
            failures++;
            $error("transducer_l15_val high during reset");
        end

endmodule

bind ao486_l15_bridge bridge_asserts #(.phy_addr_width(phy_addr_width)) u_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .l15_val       (transducer_l15_val),
    .header_ack    (l15_transducer_header_ack),
    .l15_rqtype    (transducer_l15_rqtype),
    .l15_size      (transducer_l15_size),
    .l15_address   (transducer_l15_address),
    .l15_data      (transducer_l15_data),
    .l15_nc        (transducer_l15_nc),
    .readdatavalid (transducer_ao486_mem_readdatavalid),
    .ao486_int     (ao486_int)
);

`default_nettype wire

// File: rtl/ao486_l15_bridge.sv
/*
  ao486 Avalon memory port to OpenPiton L1.5 bridge, one request in flight.
  No bursts, no instruction fill, no I/O port. Unsupported write byte
  enables become a full-word store. Unused L1.5 request fields are not
  driven here and must be tied off by the integrator.
*/
`default_nettype none

module ao486_l15_bridge import l15_bridge_pkg::*; #(
    parameter int phy_addr_width = phy_addr_default
) (
    input  logic                      clk,
    input  logic                      rst_n,

    // avalon memory port
    input  logic [avl_addr_width-1:0] ao486_transducer_mem_address,
    input  logic [data_width-1:0]     ao486_transducer_mem_writedata,
    input  logic [3:0]                ao486_transducer_mem_byteenable,
    input  logic                      ao486_transducer_mem_write,
    input  logic                      ao486_transducer_mem_read,
    output logic                      transducer_ao486_mem_waitrequest,
    output logic                      transducer_ao486_mem_readdatavalid,
    output logic [data_width-1:0]     transducer_ao486_mem_readdata,

    // l1.5 request
    output logic                      transducer_l15_val,
    output l15_rqtype_e               transducer_l15_rqtype,
    output l15_size_e                 transducer_l15_size,
    output logic [phy_addr_width-1:0] transducer_l15_address,
    output logic [l15_data_width-1:0] transducer_l15_data,
    output logic                      transducer_l15_nc,
    input  logic                      l15_transducer_header_ack,

    // l1.5 return
    input  logic                      l15_transducer_val,
    input  l15_rettype_e              l15_transducer_returntype,
    input  logic [l15_data_width-1:0] l15_transducer_data_0,
    input  logic [l15_data_width-1:0] l15_transducer_data_1,
    output logic                      transducer_l15_req_ack,
    output logic                      ao486_int
);

    logic done;

    avl_cmd_if cmd_bus ();
    l15_req_if #(.phy_addr_width(phy_addr_width)) req_bus ();

    avl_req_capture u_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_read        (ao486_transducer_mem_read),
        .mem_write       (ao486_transducer_mem_write),
        .mem_address     (ao486_transducer_mem_address),
        .mem_byteenable  (ao486_transducer_mem_byteenable),
        .mem_writedata   (ao486_transducer_mem_writedata),
        .done            (done),
        .mem_waitrequest (transducer_ao486_mem_waitrequest),
        .cmd             (cmd_bus.src)
    );

    l15_req_encoder #(.phy_addr_width(phy_addr_width)) u_encoder (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd_bus.dst),
        .req   (req_bus.src)
    );

    l15_req_issue #(.phy_addr_width(phy_addr_width)) u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .header_ack  (l15_transducer_header_ack),
        .req         (req_bus.dst),
        .l15_val     (transducer_l15_val),
        .l15_rqtype  (transducer_l15_rqtype),
        .l15_size    (transducer_l15_size),
        .l15_address (transducer_l15_address),
        .l15_data    (transducer_l15_data),
        .l15_nc      (transducer_l15_nc)
    );

    l15_resp_decoder u_decoder (
        .clk               (clk),
        .rst_n             (rst_n),
        .l15_val           (l15_transducer_val),
        .l15_returntype    (l15_transducer_returntype),
        .l15_data_0        (l15_transducer_data_0),
        .l15_data_1        (l15_transducer_data_1),
        .req               (req_bus.mon),
        .req_ack           (transducer_l15_req_ack),
        .mem_readdatavalid (transducer_ao486_mem_readdatavalid),
        .mem_readdata      (transducer_ao486_mem_readdata),
        .done              (done),
        .ao486_int         (ao486_int)
    );

endmodule

`default_nettype wire

// File: rtl/l15_resp_decoder.sv
/*
  Decodes L1.5 returns. Every return is acked in the cycle it arrives.
  Load data is one 32-bit word of the 16-byte line, picked by address
  bits 3:2 of the outstanding request. Interrupts do not complete a request.
*/
`default_nettype none

module l15_resp_decoder import l15_bridge_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      l15_val,
    input  l15_rettype_e              l15_returntype,
    input  logic [l15_data_width-1:0] l15_data_0,
    input  logic [l15_data_width-1:0] l15_data_1,
    l15_req_if.mon                    req,
    output logic                      req_ack,
    output logic                      mem_readdatavalid,
    output logic [data_width-1:0]     mem_readdata,
    output logic                      done,
    output logic                      ao486_int
);

    logic [1:0]            word_off;
    logic [data_width-1:0] word_sel;
    logic                  is_load;
    logic                  is_wakeup;

    assign req_ack   = l15_val;
    assign is_load   = l15_val && (l15_returntype == load_ret);
    assign is_wakeup = l15_val && (l15_returntype == int_ret) &&
                       (l15_data_0[17:16] == int_wakeup_code);
    assign done      = is_load || (l15_val && (l15_returntype == st_ack));

    always_ff @(posedge clk) begin
        if (req.req_valid) begin
            word_off <= req.address[3:2];
        end
    end

    // line is big-endian, word 0 sits in the top half of data_0
    always_comb begin
        case (word_off)
            2'd0:    word_sel = l15_data_0[63:32];
            2'd1:    word_sel = l15_data_0[31:0];
            2'd2:    word_sel = l15_data_1[63:32];
            default: word_sel = l15_data_1[31:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_readdatavalid <= 1'b0;
            ao486_int         <= 1'b0;
        end else begin
            mem_readdatavalid <= is_load;
            ao486_int         <= is_wakeup;
        end
    end

    // back to little-endian for the core
    always_ff @(posedge clk) begin
        if (is_load) begin
            mem_readdata <= {word_sel[7:0], word_sel[15:8],
                             word_sel[23:16], word_sel[31:24]};
        end
    end

endmodule

`default_nettype wire

// File: rtl/l15_req_issue.sv
/*
  Presents the request to the L1.5 and holds val with stable fields
  until header_ack. A new req_valid is only expected once the
  previous request has completed.
*/
`default_nettype none

module l15_req_issue import l15_bridge_pkg::*; #(
    parameter int phy_addr_width = phy_addr_default
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      header_ack,
    l15_req_if.dst                    req,
    output logic                      l15_val,
    output l15_rqtype_e               l15_rqtype,
    output l15_size_e                 l15_size,
    output logic [phy_addr_width-1:0] l15_address,
    output logic [l15_data_width-1:0] l15_data,
    output logic                      l15_nc
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            l15_val <= 1'b0;
        end else if (req.req_valid) begin
            l15_val <= 1'b1;
        end else if (l15_val && header_ack) begin
            l15_val <= 1'b0;
        end
    end

    // fields only move on a new request
    always_ff @(posedge clk) begin
        if (req.req_valid) begin
            l15_rqtype  <= req.rqtype;
            l15_size    <= req.size;
            l15_address <= req.address;
            l15_data    <= req.data;
            l15_nc      <= req.nc;
        end
    end

endmodule

`default_nettype wire

// File: rtl/l15_req_encoder.sv
/*
  Builds L1.5 requests from captured commands. Reads are 4-byte word loads.
  Writes support byte enables 0001, 0010, 0100, 1000, 0011, 1100 and 1111;
  any other pattern is sent as a 4-byte store of the whole word.
  Store data is big-endian, replicated over 64 bits.
*/
`default_nettype none

module l15_req_encoder import l15_bridge_pkg::*; #(
    parameter int phy_addr_width = phy_addr_default
) (
    input  logic   clk,
    input  logic   rst_n,
    avl_cmd_if.dst cmd,
    l15_req_if.src req
);

    logic [data_width-1:0]     wd;
    logic [data_width-1:0]     wd_be;
    logic [1:0]                offset;
    l15_size_e                 size_nxt;
    logic [l15_data_width-1:0] data_nxt;

    assign wd = cmd.writedata;
    // lowest address byte goes to the top lane
    assign wd_be = {wd[7:0], wd[15:8], wd[23:16], wd[31:24]};

    always_comb begin
        offset   = 2'd0;
        size_nxt = sz_4b;
        data_nxt = {2{wd_be}};
        if (cmd.kind == req_write) begin
            case (cmd.byteenable)
                4'b0001: begin
                    size_nxt = sz_1b;
                    data_nxt = {8{wd[7:0]}};
                end
                4'b0010: begin
                    size_nxt = sz_1b;
                    offset   = 2'd1;
                    data_nxt = {8{wd[15:8]}};
                end
                4'b0100: begin
                    size_nxt = sz_1b;
                    offset   = 2'd2;
                    data_nxt = {8{wd[23:16]}};
                end
                4'b1000: begin
                    size_nxt = sz_1b;
                    offset   = 2'd3;
                    data_nxt = {8{wd[31:24]}};
                end
                4'b0011: begin
                    size_nxt = sz_2b;
                    data_nxt = {4{wd[7:0], wd[15:8]}};
                end
                4'b1100: begin
                    size_nxt = sz_2b;
                    offset   = 2'd2;
                    data_nxt = {4{wd[23:16], wd[31:24]}};
                end
                // full word, also the fallback for split patterns
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req.req_valid <= 1'b0;
        end else begin
            req.req_valid <= cmd.cmd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.cmd_valid) begin
            req.rqtype  <= (cmd.kind == req_write) ? store_rq : load_rq;
            req.size    <= size_nxt;
            req.address <= phy_addr_width'({cmd.word_addr, offset});
            req.nc      <= cmd.word_addr[avl_addr_width-1];
            req.data    <= data_nxt;
        end
    end

endmodule

`default_nettype wire

// File: rtl/avl_req_capture.sv
/*
  Avalon command capture. Single beat only, burstcount is not supported.
  waitrequest is high from the cycle after accept until done.
  Write wins if read and write are both high.
*/
`default_nettype none

module avl_req_capture import l15_bridge_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic [avl_addr_width-1:0] mem_address,
    input  logic [3:0]                mem_byteenable,
    input  logic [data_width-1:0]     mem_writedata,
    input  logic                      done,
    output logic                      mem_waitrequest,
    avl_cmd_if.src                    cmd
);

    logic busy;
    logic accept;

    assign accept          = (mem_read | mem_write) & ~busy;
    assign mem_waitrequest = busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            cmd.cmd_valid <= 1'b0;
        end else begin
            cmd.cmd_valid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // command payload
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.kind       <= mem_write ? req_write : req_read;
            cmd.word_addr  <= mem_address;
            cmd.byteenable <= mem_byteenable;
            cmd.writedata  <= mem_writedata;
        end
    end

endmodule

`default_nettype wire

// File: common/l15_req_if.sv
/*
  Encoded L1.5 request, one req_valid strobe per request.
  No back-pressure, only one request is ever in flight.
*/
`default_nettype none

interface l15_req_if import l15_bridge_pkg::*; #(
    parameter int phy_addr_width = phy_addr_default
) ();

    logic                      req_valid;
    l15_rqtype_e               rqtype;
    l15_size_e                 size;
    logic [phy_addr_width-1:0] address;
    logic                      nc;
    logic [l15_data_width-1:0] data;

    modport src (output req_valid, rqtype, size, address, nc, data);

    modport dst (input req_valid, rqtype, size, address, nc, data);

    // return path only needs the word offset
    modport mon (input req_valid, address);

endinterface

`default_nettype wire

// File: common/avl_cmd_if.sv
/*
  Captured Avalon command, one cmd_valid strobe per accepted command.
  Fields are only meaningful in the cycle of the strobe.
*/
`default_nettype none

interface avl_cmd_if import l15_bridge_pkg::*; ();

    logic                      cmd_valid;
    req_kind_e                 kind;
    logic [avl_addr_width-1:0] word_addr;
    logic [3:0]                byteenable;
    logic [data_width-1:0]     writedata;

    modport src (
        output cmd_valid, kind, word_addr, byteenable, writedata
    );

    modport dst (
        input cmd_valid, kind, word_addr, byteenable, writedata
    );

endinterface

`default_nettype wire

// File: common/l15_bridge_pkg.sv
/*
  Shared widths and encodings for the ao486 to L1.5 bridge.
  Return and request type values follow the OpenPiton L1.5 encoding,
  only the subset used by the bridge is listed.
*/
`default_nettype none

package l15_bridge_pkg;

    // avalon side, word addressed
    localparam int avl_addr_width = 30;
    localparam int data_width     = 32;

    // l1.5 side
    localparam int l15_data_width   = 64;
    localparam int phy_addr_default = 40;

    typedef enum logic {
        req_read  = 1'b0,
        req_write = 1'b1
    } req_kind_e;

    typedef enum logic [4:0] {
        load_rq  = 5'd0,
        store_rq = 5'd1
    } l15_rqtype_e;

    typedef enum logic [3:0] {
        load_ret = 4'd0,
        st_ack   = 4'd4,
        int_ret  = 4'd7
    } l15_rettype_e;

    typedef enum logic [2:0] {
        sz_1b = 3'd0,
        sz_2b = 3'd1,
        sz_4b = 3'd2
    } l15_size_e;

    // data_0[17:16] of an interrupt return
    localparam logic [1:0] int_wakeup_code = 2'b01;

endpackage

`default_nettype wire
